// File: include/board_params.svh
`ifndef BOARD_PARAMS_SVH
`define BOARD_PARAMS_SVH

// Frame memory
`define ADDR_W        8
`define DATA_W        8
`define MEM_DEPTH     256

// UART bit time in clocks
`define CLKS_PER_BIT  8

// Shrunk video timing, one pixel per clock
`define H_ACTIVE      16
`define H_FRONT       2
`define H_SYNC        4
`define H_BACK        2
`define H_TOTAL       24

`define V_ACTIVE      8
`define V_FRONT       1
`define V_SYNC        2
`define V_BACK        1
`define V_TOTAL       12

// Seven-segment refresh, digit flips when the counter wraps
`define SCAN_DIV_W    4

`endif

// File: logic/bus_pkg.sv
`default_nettype none

`include "board_params.svh"

package bus_pkg;

    // Shared frame memory bus
    typedef logic [`ADDR_W-1:0] addr_t;
    typedef logic [`DATA_W-1:0] data_t;

    // Masters, listed in priority order
    typedef enum logic [1:0] {
        M_VGA,
        M_UART,
        M_SEG
    } master_t;

endpackage : bus_pkg

`default_nettype wire

// File: logic/video_pkg.sv
`default_nettype none

package video_pkg;

    // Scan counters
    typedef logic [4:0] hcount_t;
    typedef logic [3:0] vcount_t;

    // RGB 3:3:2, red in the top bits
    typedef logic [7:0] pixel_t;

    // UART receiver
    typedef enum logic [1:0] {
        RX_IDLE,
        RX_START,
        RX_DATA,
        RX_STOP
    } rx_state_t;

endpackage : video_pkg

`default_nettype wire

// File: logic/frame_mem_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

`include "board_params.svh"

module frame_mem_arbiter (
    input  logic           clk,
    input  logic           arst_n_i,
    input  logic           vga_req_i,
    input  bus_pkg::addr_t vga_addr_i,
    input  logic           uart_req_i,
    input  bus_pkg::addr_t uart_addr_i,
    input  bus_pkg::data_t uart_wdata_i,
    input  logic           seg_req_i,
    input  bus_pkg::addr_t seg_addr_i,
    output logic           vga_gnt_o,
    output logic           uart_gnt_o,
    output logic           seg_gnt_o,
    output bus_pkg::data_t rdata_o
);
    import bus_pkg::*;

    data_t   mem [`MEM_DEPTH];
    data_t   rdata_q;
    addr_t   sel_addr;
    master_t owner_q;
    logic    busy_q;
    logic    any_gnt;

    // Fixed priority, VGA first
    assign vga_gnt_o  = vga_req_i;
    assign uart_gnt_o = uart_req_i & ~vga_req_i;
    assign seg_gnt_o  = seg_req_i & ~vga_req_i & ~uart_req_i;
    assign any_gnt    = vga_req_i | uart_req_i | seg_req_i;

    // Read address, only VGA and the segment reader read
    always_comb begin
        sel_addr = seg_addr_i;
        if (vga_req_i) begin
            sel_addr = vga_addr_i;
        end
    end

    always_ff @(posedge clk) begin
        if (uart_gnt_o) begin
            mem[uart_addr_i] <= uart_wdata_i;
        end
        if (vga_gnt_o || seg_gnt_o) begin
            rdata_q <= mem[sel_addr];
        end
    end

    // Who owned the bus last cycle
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            owner_q <= M_VGA;
            busy_q  <= 1'b0;
        end else begin
            busy_q <= any_gnt;
            if (vga_gnt_o) begin
                owner_q <= M_VGA;
            end else if (uart_gnt_o) begin
                owner_q <= M_UART;
            end else if (seg_gnt_o) begin
                owner_q <= M_SEG;
            end
        end
    end

    // Read bus idles at zero after a write or an empty cycle
    assign rdata_o = (busy_q && owner_q != M_UART) ? rdata_q : '0;

endmodule : frame_mem_arbiter

`default_nettype wire

// File: logic/uart_loader.sv
`timescale 1ns/1ps
`default_nettype none

`include "board_params.svh"

module uart_loader (
    input  logic           clk,
    input  logic           arst_n_i,
    input  logic           uart_rxd_i,
    input  logic           gnt_i,
    output logic           req_o,
    output bus_pkg::addr_t addr_o,
    output bus_pkg::data_t wdata_o
);
    import bus_pkg::*;
    import video_pkg::*;

    logic                             rxd_meta_q;
    logic                             rxd_q;
    rx_state_t                        state_q;
    logic [$clog2(`CLKS_PER_BIT)-1:0] clk_cnt_q;
    logic [$clog2(`DATA_W)-1:0]       bit_idx_q;
    data_t                            shift_q;
    data_t                            wdata_q;
    addr_t                            addr_q;
    logic                             req_q;
    logic                             mid_start;
    logic                             mid_bit;
    logic                             byte_ok;

    // Two-flop synchroniser, line idles high
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            rxd_meta_q <= 1'b1;
            rxd_q      <= 1'b1;
        end else begin
            rxd_meta_q <= uart_rxd_i;
            rxd_q      <= rxd_meta_q;
        end
    end

    assign mid_start = 32'(clk_cnt_q) == `CLKS_PER_BIT / 2 - 1;
    assign mid_bit   = 32'(clk_cnt_q) == `CLKS_PER_BIT - 1;
    assign byte_ok   = (state_q == RX_STOP) && mid_bit && rxd_q;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q   <= RX_IDLE;
            clk_cnt_q <= '0;
            bit_idx_q <= '0;
        end else begin
            clk_cnt_q <= clk_cnt_q + 1'b1;
            case (state_q)
                RX_IDLE: begin
                    clk_cnt_q <= '0;
                    if (!rxd_q) begin
                        state_q <= RX_START;
                    end
                end
                RX_START: begin
                    // Glitch on the start bit goes back to idle
                    if (mid_start) begin
                        clk_cnt_q <= '0;
                        bit_idx_q <= '0;
                        state_q   <= rxd_q ? RX_IDLE : RX_DATA;
                    end
                end
                RX_DATA: begin
                    if (mid_bit) begin
                        clk_cnt_q <= '0;
                        bit_idx_q <= bit_idx_q + 1'b1;
                        if (&bit_idx_q) begin
                            state_q <= RX_STOP;
                        end
                    end
                end
                RX_STOP: begin
                    if (mid_bit) begin
                        state_q <= RX_IDLE;
                    end
                end
                default: state_q <= RX_IDLE;
            endcase
        end
    end

    // LSB first
    always_ff @(posedge clk) begin
        if (state_q == RX_DATA && mid_bit) begin
            shift_q <= {rxd_q, shift_q[`DATA_W-1:1]};
        end
        if (byte_ok) begin
            wdata_q <= shift_q;
        end
    end

    // Pending write, address steps only once the byte is in memory
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            req_q  <= 1'b0;
            addr_q <= '0;
        end else if (byte_ok) begin
            req_q <= 1'b1;
        end else if (req_q && gnt_i) begin
            req_q  <= 1'b0;
            addr_q <= addr_q + 1'b1;
        end
    end

    assign req_o   = req_q;
    assign addr_o  = addr_q;
    assign wdata_o = wdata_q;

endmodule : uart_loader

`default_nettype wire

// File: logic/vga_scanout.sv
`timescale 1ns/1ps
`default_nettype none

`include "board_params.svh"

module vga_scanout (
    input  logic           clk,
    input  logic           arst_n_i,
    input  logic           gnt_i,
    input  bus_pkg::data_t rdata_i,
    output logic           req_o,
    output bus_pkg::addr_t addr_o,
    output logic           vga_hsync_o,
    output logic           vga_vsync_o,
    output logic [3:0]     vga_r_o,
    output logic [3:0]     vga_g_o,
    output logic [3:0]     vga_b_o
);
    import bus_pkg::*;
    import video_pkg::*;

    hcount_t h_q;
    vcount_t v_q;
    int      h_pos;
    int      v_pos;
    logic    active;
    logic    hsync_n;
    logic    vsync_n;
    logic    fetch_q;
    logic    hsync1_q;
    logic    vsync1_q;
    pixel_t  pix;

    assign h_pos = int'(h_q);
    assign v_pos = int'(v_q);

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            h_q <= '0;
            v_q <= '0;
        end else if (h_pos == `H_TOTAL - 1) begin
            h_q <= '0;
            if (v_pos == `V_TOTAL - 1) begin
                v_q <= '0;
            end else begin
                v_q <= v_q + 1'b1;
            end
        end else begin
            h_q <= h_q + 1'b1;
        end
    end

    assign active  = (h_pos < `H_ACTIVE) && (v_pos < `V_ACTIVE);
    assign hsync_n = !((h_pos >= `H_ACTIVE + `H_FRONT) &&
                       (h_pos < `H_ACTIVE + `H_FRONT + `H_SYNC));
    assign vsync_n = !((v_pos >= `V_ACTIVE + `V_FRONT) &&
                       (v_pos < `V_ACTIVE + `V_FRONT + `V_SYNC));

    // One fetch per active pixel, row-major
    assign req_o  = active;
    assign addr_o = addr_t'(v_pos * `H_ACTIVE + h_pos);

    assign pix = pixel_t'(rdata_i);

    // Stage 1 waits on memory, stage 2 registers the pins
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            fetch_q     <= 1'b0;
            hsync1_q    <= 1'b1;
            vsync1_q    <= 1'b1;
            vga_hsync_o <= 1'b1;
            vga_vsync_o <= 1'b1;
            vga_r_o     <= '0;
            vga_g_o     <= '0;
            vga_b_o     <= '0;
        end else begin
            fetch_q     <= active & gnt_i;
            hsync1_q    <= hsync_n;
            vsync1_q    <= vsync_n;
            vga_hsync_o <= hsync1_q;
            vga_vsync_o <= vsync1_q;
            if (fetch_q) begin
                vga_r_o <= {pix[7:5], pix[7]};
                vga_g_o <= {pix[4:2], pix[4]};
                vga_b_o <= {pix[1:0], pix[1:0]};
            end else begin
                vga_r_o <= '0;
                vga_g_o <= '0;
                vga_b_o <= '0;
            end
        end
    end

endmodule : vga_scanout

`default_nettype wire

// File: logic/seg_display.sv
`timescale 1ns/1ps
`default_nettype none

`include "board_params.svh"

module seg_display (
    input  logic              clk,
    input  logic              arst_n_i,
    input  logic [`ADDR_W-1:0] switch_i,
    input  logic              gnt_i,
    input  bus_pkg::data_t    rdata_i,
    output logic              req_o,
    output bus_pkg::addr_t    addr_o,
    output logic [15:0]       led_o,
    output logic [7:0]        seg_sel_o,
    output logic [7:0]        seg_bit_o
);
    import bus_pkg::*;

    logic                   req_q;
    logic                   pend_q;
    addr_t                  addr_q;
    logic [15:0]            led_q;
    logic [`SCAN_DIV_W-1:0] scan_q;
    logic [7:0]             sel_q;
    logic [3:0]             nibble;

    // Segments gfedcba, active high here
    function automatic logic [6:0] hex_segments(input logic [3:0] nib);
        logic [6:0] seg;
        case (nib)
            4'h0: seg = 7'h3f;
            4'h1: seg = 7'h06;
            4'h2: seg = 7'h5b;
            4'h3: seg = 7'h4f;
            4'h4: seg = 7'h66;
            4'h5: seg = 7'h6d;
            4'h6: seg = 7'h7d;
            4'h7: seg = 7'h07;
            4'h8: seg = 7'h7f;
            4'h9: seg = 7'h6f;
            4'ha: seg = 7'h77;
            4'hb: seg = 7'h7c;
            4'hc: seg = 7'h39;
            4'hd: seg = 7'h5e;
            4'he: seg = 7'h79;
            default: seg = 7'h71;
        endcase
        return seg;
    endfunction

    // Read loop, next request right after the data lands
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            req_q  <= 1'b0;
            pend_q <= 1'b0;
            led_q  <= '0;
        end else if (pend_q) begin
            pend_q <= 1'b0;
            req_q  <= 1'b1;
            led_q  <= {addr_q, rdata_i};
        end else if (req_q && gnt_i) begin
            req_q  <= 1'b0;
            pend_q <= 1'b1;
        end else if (!req_q) begin
            req_q <= 1'b1;
        end
    end

    // Address follows the switches between reads
    always_ff @(posedge clk) begin
        if (!req_q) begin
            addr_q <= switch_i;
        end
    end

    // Digit refresh, both selects high until the first tick
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            scan_q <= '0;
            sel_q  <= 8'hff;
        end else begin
            scan_q <= scan_q + 1'b1;
            if (&sel_q[1:0]) begin
                sel_q <= 8'hfe;
            end else if (&scan_q) begin
                sel_q <= {6'h3f, sel_q[0], sel_q[1]};
            end
        end
    end

    assign nibble = sel_q[0] ? led_q[7:4] : led_q[3:0];

    assign req_o     = req_q;
    assign addr_o    = addr_q;
    assign led_o     = led_q;
    assign seg_sel_o = sel_q;
    // Decimal point stays dark
    assign seg_bit_o = (&sel_q[1:0]) ? 8'hff : {1'b1, ~hex_segments(nibble)};

endmodule : seg_display

`default_nettype wire

// File: logic/board_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "board_params.svh"

module board_top (
    input  logic               clk,
    input  logic               arst_n_i,
    // GPIO
    input  logic [`ADDR_W-1:0] switch_i,
    output logic [15:0]        led_o,
    output logic [7:0]         seg_sel_o,
    output logic [7:0]         seg_bit_o,
    // UART
    input  logic               uart_rxd_i,
    // VGA
    output logic [3:0]         vga_r_o,
    output logic [3:0]         vga_g_o,
    output logic [3:0]         vga_b_o,
    output logic               vga_hsync_o,
    output logic               vga_vsync_o
);
    import bus_pkg::*;

    logic  vga_req;
    logic  vga_gnt;
    addr_t vga_addr;
    logic  uart_req;
    logic  uart_gnt;
    addr_t uart_addr;
    data_t uart_wdata;
    logic  seg_req;
    logic  seg_gnt;
    addr_t seg_addr;
    data_t rdata;

    frame_mem_arbiter u_arbiter (
        .clk          (clk),
        .arst_n_i     (arst_n_i),
        .vga_req_i    (vga_req),
        .vga_addr_i   (vga_addr),
        .uart_req_i   (uart_req),
        .uart_addr_i  (uart_addr),
        .uart_wdata_i (uart_wdata),
        .seg_req_i    (seg_req),
        .seg_addr_i   (seg_addr),
        .vga_gnt_o    (vga_gnt),
        .uart_gnt_o   (uart_gnt),
        .seg_gnt_o    (seg_gnt),
        .rdata_o      (rdata)
    );

    uart_loader u_uart (
        .clk        (clk),
        .arst_n_i   (arst_n_i),
        .uart_rxd_i (uart_rxd_i),
        .gnt_i      (uart_gnt),
        .req_o      (uart_req),
        .addr_o     (uart_addr),
        .wdata_o    (uart_wdata)
    );

    vga_scanout u_vga (
        .clk         (clk),
        .arst_n_i    (arst_n_i),
        .gnt_i       (vga_gnt),
        .rdata_i     (rdata),
        .req_o       (vga_req),
        .addr_o      (vga_addr),
        .vga_hsync_o (vga_hsync_o),
        .vga_vsync_o (vga_vsync_o),
        .vga_r_o     (vga_r_o),
        .vga_g_o     (vga_g_o),
        .vga_b_o     (vga_b_o)
    );

    seg_display u_seg (
        .clk       (clk),
        .arst_n_i  (arst_n_i),
        .switch_i  (switch_i),
        .gnt_i     (seg_gnt),
        .rdata_i   (rdata),
        .req_o     (seg_req),
        .addr_o    (seg_addr),
        .led_o     (led_o),
        .seg_sel_o (seg_sel_o),
        .seg_bit_o (seg_bit_o)
    );

endmodule : board_top

`default_nettype wire

// File: verification/board_top_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "board_params.svh"

module board_top_tb;
    import video_pkg::*;

    localparam int NUM_BYTES  = 128;
    localparam int NUM_READS  = 16;
    localparam int READ_WAIT  = 40;
    localparam int BYTE_CLKS  = 11 * `CLKS_PER_BIT;
    localparam int FRAME_CLKS = `H_TOTAL * `V_TOTAL;
    localparam int TIMEOUT_CYCLES = (NUM_BYTES + 2) * BYTE_CLKS + (NUM_READS + 2) * READ_WAIT
                                  + 4 * FRAME_CLKS + 2000;

    logic               clk;
    logic               arst_n_i;
    logic [`ADDR_W-1:0] switch_i;
    logic               uart_rxd_i;
    logic [15:0]        led_o;
    logic [7:0]         seg_sel_o;
    logic [7:0]         seg_bit_o;
    logic [3:0]         vga_r_o;
    logic [3:0]         vga_g_o;
    logic [3:0]         vga_b_o;
    logic               vga_hsync_o;
    logic               vga_vsync_o;
    logic [11:0]        rgb;

    logic [7:0]  model_mem [256];
    logic [7:0]  model_addr;
    logic [31:0] lcg_state = 32'd3;
    int          mismatch_count = 0;
    int          other_count = 0;
    int          cycle_cnt = 0;
    logic        rst_done = 1'b0;
    logic        scan_on = 1'b0;
    logic        scan_done = 1'b0;

    board_top dut (
        .clk         (clk),
        .arst_n_i    (arst_n_i),
        .switch_i    (switch_i),
        .uart_rxd_i  (uart_rxd_i),
        .led_o       (led_o),
        .seg_sel_o   (seg_sel_o),
        .seg_bit_o   (seg_bit_o),
        .vga_r_o     (vga_r_o),
        .vga_g_o     (vga_g_o),
        .vga_b_o     (vga_b_o),
        .vga_hsync_o (vga_hsync_o),
        .vga_vsync_o (vga_vsync_o)
    );

    assign rgb = {vga_r_o, vga_g_o, vga_b_o};

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic logic [7:0] next_rand();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state[23:16];
    endfunction

    // 3:3:2 pixel widened to 4:4:4 by repeating top bits
    function automatic logic [11:0] expand_rgb(input pixel_t p);
        return {p[7:5], p[7], p[4:2], p[4], p[1:0], p[1:0]};
    endfunction

    // Active-low segments, DP dark
    function automatic logic [7:0] seg_code(input logic [3:0] nib);
        logic [7:0] code;
        case (nib)
            4'h0: code = 8'hc0;
            4'h1: code = 8'hf9;
            4'h2: code = 8'ha4;
            4'h3: code = 8'hb0;
            4'h4: code = 8'h99;
            4'h5: code = 8'h92;
            4'h6: code = 8'h82;
            4'h7: code = 8'hf8;
            4'h8: code = 8'h80;
            4'h9: code = 8'h90;
            4'ha: code = 8'h88;
            4'hb: code = 8'h83;
            4'hc: code = 8'hc6;
            4'hd: code = 8'ha1;
            4'he: code = 8'h86;
            default: code = 8'h8e;
        endcase
        return code;
    endfunction

    task automatic report_mismatch(input string name, input logic [15:0] exp,
                                   input logic [15:0] act);
        mismatch_count = mismatch_count + 1;
        $display("MISMATCH at %0t: %s expected %h, got %h", $time, name, exp, act);
    endtask

    task automatic print_counts();
        $display("Error counts: %0d mismatches, %0d other errors", mismatch_count, other_count);
    endtask

    task automatic check_reset_state();
        assert (vga_hsync_o == 1'b1) else report_mismatch("vga_hsync_o", 16'h1, 16'(vga_hsync_o));
        assert (vga_vsync_o == 1'b1) else report_mismatch("vga_vsync_o", 16'h1, 16'(vga_vsync_o));
        assert (rgb == 12'h000) else report_mismatch("vga_rgb", 16'h0, 16'(rgb));
        assert (led_o == 16'h0000) else report_mismatch("led_o", 16'h0, led_o);
        assert (seg_sel_o == 8'hff) else report_mismatch("seg_sel_o", 16'hff, 16'(seg_sel_o));
        assert (seg_bit_o == 8'hff) else report_mismatch("seg_bit_o", 16'hff, 16'(seg_bit_o));
    endtask

    // Holds one UART bit for a full bit time
    task automatic drive_bit(input logic value);
        uart_rxd_i <= value;
        repeat (`CLKS_PER_BIT) @(posedge clk);
    endtask

    // 8N1 frame, LSB first, then one idle bit
    task automatic send_frame(input logic [7:0] data, input logic stop_bit);
        drive_bit(1'b0);
        for (int i = 0; i < 8; i++) begin
            drive_bit(data[i]);
        end
        drive_bit(stop_bit);
        drive_bit(1'b1);
    endtask

    task automatic read_back(input logic [7:0] addr);
        int waited;
        waited = 0;
        switch_i <= addr;
        @(posedge clk);
        while (led_o[15:8] != addr && waited < READ_WAIT) begin
            @(posedge clk);
            waited = waited + 1;
        end
        if (led_o[15:8] != addr) begin
            other_count = other_count + 1;
            $display("Readback of address %h never reached the LEDs within %0d clocks",
                     addr, READ_WAIT);
        end else begin
            assert (led_o[7:0] == model_mem[addr])
                else report_mismatch("led_o[7:0]", 16'(model_mem[addr]), 16'(led_o[7:0]));
        end
    endtask

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            other_count = other_count + 1;
            $display("Timeout after %0d cycles, the run did not finish", cycle_cnt);
            print_counts();
            $display("RESULT: FAIL");
            $finish;
        end
    end

    // Sync pulse widths and periods
    logic hs_prev = 1'b1;
    logic vs_prev = 1'b1;
    logic h_seen = 1'b0;
    logic v_seen = 1'b0;
    int   h_fall_at = 0;
    int   v_fall_at = 0;

    always @(posedge clk) begin
        if (rst_done) begin
            if (hs_prev && !vga_hsync_o) begin
                if (h_seen) begin
                    assert (cycle_cnt - h_fall_at == `H_TOTAL)
                        else report_mismatch("hsync period", 16'(`H_TOTAL),
                                             16'(cycle_cnt - h_fall_at));
                end
                h_fall_at = cycle_cnt;
                h_seen    = 1'b1;
            end
            if (!hs_prev && vga_hsync_o && h_seen) begin
                assert (cycle_cnt - h_fall_at == `H_SYNC)
                    else report_mismatch("hsync width", 16'(`H_SYNC), 16'(cycle_cnt - h_fall_at));
            end
            if (vs_prev && !vga_vsync_o) begin
                if (v_seen) begin
                    assert (cycle_cnt - v_fall_at == FRAME_CLKS)
                        else report_mismatch("vsync period", 16'(FRAME_CLKS),
                                             16'(cycle_cnt - v_fall_at));
                end
                v_fall_at = cycle_cnt;
                v_seen    = 1'b1;
            end
            if (!vs_prev && vga_vsync_o && v_seen) begin
                assert (cycle_cnt - v_fall_at == `V_SYNC * `H_TOTAL)
                    else report_mismatch("vsync width", 16'(`V_SYNC * `H_TOTAL),
                                         16'(cycle_cnt - v_fall_at));
            end
        end
        hs_prev = vga_hsync_o;
        vs_prev = vga_vsync_o;
    end

    // Pixel scanout over one full frame, vsync rise to vsync rise
    logic        hs_scan_prev = 1'b1;
    logic        vs_scan_prev = 1'b1;
    logic        frame_seen = 1'b0;
    int          hrise_cnt = 0;
    int          since_hrise = 1000;
    int          row;
    int          col;
    logic [11:0] rgb_exp;

    always @(posedge clk) begin
        if (scan_on && !scan_done) begin
            if (vga_vsync_o && !vs_scan_prev) begin
                if (frame_seen) begin
                    scan_done = 1'b1;
                end
                frame_seen = 1'b1;
                hrise_cnt  = 0;
            end
            if (vga_hsync_o && !hs_scan_prev) begin
                hrise_cnt   = hrise_cnt + 1;
                since_hrise = 0;
            end else begin
                since_hrise = since_hrise + 1;
            end
            if (frame_seen && !scan_done) begin
                row = hrise_cnt - `V_BACK;
                col = since_hrise - `H_BACK;
                rgb_exp = 12'h000;
                if (row >= 0 && row < `V_ACTIVE && col >= 0 && col < `H_ACTIVE) begin
                    rgb_exp = expand_rgb(model_mem[8'(row * `H_ACTIVE + col)]);
                end
                assert (rgb == rgb_exp) else report_mismatch("vga_rgb", 16'(rgb_exp), 16'(rgb));
            end
        end
        hs_scan_prev = vga_hsync_o;
        vs_scan_prev = vga_vsync_o;
    end

    always @(posedge clk) begin
        if (!seg_sel_o[0]) begin
            assert (seg_bit_o == seg_code(led_o[3:0]))
                else report_mismatch("seg_bit_o", 16'(seg_code(led_o[3:0])), 16'(seg_bit_o));
        end
        if (!seg_sel_o[1]) begin
            assert (seg_bit_o == seg_code(led_o[7:4]))
                else report_mismatch("seg_bit_o", 16'(seg_code(led_o[7:4])), 16'(seg_bit_o));
        end
    end

    // One digit lit at a time once the refresh has started
    logic sel_live = 1'b0;

    assert property (@(posedge clk) disable iff (!sel_live)
        (seg_sel_o[7:2] == 6'h3f) && (seg_sel_o[1] != seg_sel_o[0]))
    else begin
        other_count = other_count + 1;
        $display("At %0t seg_sel_o is %b, but exactly one of digits 0 and 1 should be selected",
                 $time, seg_sel_o);
    end

    initial begin
        logic [7:0] data;
        arst_n_i   = 1'b0;
        switch_i   = '0;
        uart_rxd_i = 1'b1;
        model_addr = '0;

        @(posedge clk);
        @(posedge clk);
        check_reset_state();
        arst_n_i <= 1'b1;
        @(posedge clk);
        check_reset_state();
        rst_done <= 1'b1;
        sel_live <= 1'b1;

        for (int i = 0; i < NUM_BYTES; i++) begin
            data = next_rand();
            send_frame(data, 1'b1);
            model_mem[model_addr] = data;
            model_addr = model_addr + 1'b1;
        end
        // Last write still in flight
        repeat (24) @(posedge clk);

        for (int i = 0; i < NUM_READS; i++) begin
            read_back(next_rand() & 8'h7f);
        end

        // Bad stop bit, byte must not take an address
        send_frame(next_rand(), 1'b0);
        data = next_rand();
        send_frame(data, 1'b1);
        model_mem[model_addr] = data;
        model_addr = model_addr + 1'b1;
        repeat (24) @(posedge clk);
        read_back(8'd128);
        read_back(8'd127);

        scan_on = 1'b1;
        while (!scan_done) begin
            @(posedge clk);
        end

        print_counts();
        if (mismatch_count + other_count == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule : board_top_tb

`default_nettype wire

// File: flist.f
+incdir+include
logic/bus_pkg.sv
logic/video_pkg.sv
logic/frame_mem_arbiter.sv
logic/uart_loader.sv
logic/vga_scanout.sv
logic/seg_display.sv
logic/board_top.sv
verification/board_top_tb.sv

// File: Makefile
VERILATOR  ?= verilator
LINT_FLAGS ?= --lint-only -Wall --timing
SIM_FLAGS  ?= --binary --timing --assert
TB_TOP     ?= board_top_tb
RTL_TOP    ?= board_top
FLIST      ?= flist.f
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log
PASS_MSG   := RESULT: PASS

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FLIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TB_TOP) -Mdir $(OBJ_DIR) -f $(FLIST)
	./$(OBJ_DIR)/V$(TB_TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
